/* build.f */
common/sta_pkg.sv
common/sa_feed_if.sv
systolic/sa_pe.sv
systolic/sa_skew_feeder.sv
logic/sa_result_drain.sv
systolic/sta_core.sv
verification/tb_sta_core.sv

/* Bender.yml */
package:
  name: sta_core

sources:
  - files:
      - common/sta_pkg.sv
      - common/sa_feed_if.sv
      - systolic/sa_pe.sv
      - systolic/sa_skew_feeder.sv
      - logic/sa_result_drain.sv
      - systolic/sta_core.sv
  - target: test
    files:
      - verification/tb_sta_core.sv

/* verification/sta_input.hex */
// Line 1: tile count. Per tile: depth bias shift relu_bypass, then one line per step
// Step line: a word (a[0] in bits 7:0 .. a[3] in 31:24), b word (same byte order)
00000006
// Small positive matrix product
00000002 00000000 00000000 00000000
04030201 01020101
03010102 01010203
// Bias added once with depth 1
00000001 00000005 00000000 00000000
04030201 03010002
// Mixed signs, ReLU active
00000002 FFFFFFFD 00000000 00000000
FC03FE01 01FF0302
01FF01FF 0002FE01
// Same tile, ReLU bypassed
00000002 FFFFFFFD 00000000 00000001
FC03FE01 01FF0302
01FF01FF 0002FE01
// Large products, no shift, clamps at both bounds
00000001 00000000 00000000 00000001
9C64807F FF32807F
// Large products, shift 8, still clamps on the biggest sums
00000003 00000001 00000008 00000001
9C64807F FF32807F
9C64807F FF32807F
9C64807F FF32807F

/* verification/tb_sta_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sta_core
    import sta_pkg::*;
();

    localparam int    SA_N        = 4;
    localparam int    IDX_W       = $clog2(SA_N);
    localparam int    N_OUT       = SA_N * SA_N;            // Results per tile
    localparam int    FLUSH_DELAY = 2 * SA_N - 1;           // Skew clear time after done
    localparam int    HDR_WORDS   = 4;                      // depth, bias, shift, relu_bypass
    localparam int    MEM_WORDS   = 256;
    localparam string DATA_FILE   = "verification/sta_input.hex";

    logic             clk;
    logic             reset;
    logic             load_bias;
    sa_acc_t          bias_value;
    logic             in_valid;
    sa_data_t         a_vec [SA_N];
    sa_data_t         b_vec [SA_N];
    logic             done;
    sa_shift_t        shift;
    logic             relu_bypass;
    logic             out_valid;
    sa_data_t         out_val;
    logic [IDX_W-1:0] out_row;
    logic [IDX_W-1:0] out_col;
    logic             sta_idle;

    logic [31:0] mem [MEM_WORDS];                           // Raw tile records
    int          exp_val_q [$];                             // Row-major expected results
    int          exp_row_q [$];
    int          exp_col_q [$];
    int          done_cyc_q [$];                            // Cycle of each done
    int          cyc;                                       // Rising edges so far
    int          last_done;
    int          n_tiles;
    int          max_depth;
    int          wd_cycles;
    int          n_checks;
    int          err_count;
    int          n_recv;
    int          first_cyc;

    sta_core #(.SA_N(SA_N)) u_dut (
        .clk(clk), .reset(reset), .load_bias(load_bias), .bias_value(bias_value),
        .in_valid(in_valid), .a_vec(a_vec), .b_vec(b_vec), .done(done), .shift(shift),
        .relu_bypass(relu_bypass), .out_valid(out_valid), .out_val(out_val),
        .out_row(out_row), .out_col(out_col), .sta_idle(sta_idle)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                                   // 10 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic next_cycle();
        @(posedge clk);
        #1;                                                 // Drive just after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    // Bias plus dot product over depth, then shift, ReLU and int8 clamp
    task automatic queue_expected(input int base);
        int depth;
        int acc;
        int a_el;
        int b_el;
        depth = mem[base];
        for (int i = 0; i < SA_N; i++) begin
            for (int j = 0; j < SA_N; j++) begin
                acc = mem[base+1];
                for (int k = 0; k < depth; k++) begin
                    a_el = sa_data_t'(mem[base + HDR_WORDS + 2*k][8*i +: 8]);
                    b_el = sa_data_t'(mem[base + HDR_WORDS + 2*k + 1][8*j +: 8]);
                    acc += a_el * b_el;
                end
                acc = acc >>> mem[base+2][4:0];             // Arithmetic shift
                if (!mem[base+3][0] && acc < 0) begin
                    acc = 0;
                end
                if (acc > SAT_MAX) begin
                    acc = SAT_MAX;
                end else if (acc < SAT_MIN) begin
                    acc = SAT_MIN;
                end
                exp_val_q.push_back(acc);
                exp_row_q.push_back(i);
                exp_col_q.push_back(j);
            end
        end
    endtask

    task automatic issue_tile(input int base);
        int depth;
        depth = mem[base];
        queue_expected(base);
        next_cycle();
        while (cyc < last_done + FLUSH_DELAY + 2) begin
            next_cycle();                                   // Earliest is the cycle after flush
        end
        load_bias   = 1'b1;
        bias_value  = mem[base+1];
        shift       = mem[base+2][4:0];                     // Held until this tile's flush
        relu_bypass = mem[base+3][0];
        next_cycle();
        load_bias = 1'b0;
        for (int k = 0; k < depth; k++) begin
            in_valid = 1'b1;                                // One depth step
            for (int i = 0; i < SA_N; i++) begin
                a_vec[i] = sa_data_t'(mem[base + HDR_WORDS + 2*k][8*i +: 8]);
                b_vec[i] = sa_data_t'(mem[base + HDR_WORDS + 2*k + 1][8*i +: 8]);
            end
            next_cycle();
        end
        in_valid = 1'b0;
        while (cyc < last_done + N_OUT) begin
            next_cycle();                                   // Flushes a full drain apart
        end
        done = 1'b1;
        done_cyc_q.push_back(cyc);
        last_done = cyc;
        next_cycle();
        done = 1'b0;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int base;
        cyc = 0;
        last_done = -1000;                                  // No previous tile
        n_checks = 0;
        err_count = 0;
        n_recv = 0;
        n_tiles = 0;
        max_depth = 0;
        reset = 1'b1;
        load_bias = 1'b0;
        bias_value = '0;
        in_valid = 1'b0;
        done = 1'b0;
        shift = '0;
        relu_bypass = 1'b0;
        for (int i = 0; i < SA_N; i++) begin
            a_vec[i] = '0;
            b_vec[i] = '0;
        end
        $readmemh(DATA_FILE, mem);
        if ($isunknown(mem[0])) begin
            $display("Could not read tile records from %s", DATA_FILE);
            err_count++;
        end else begin
            n_tiles = mem[0];
        end
        base = 1;
        for (int t = 0; t < n_tiles; t++) begin
            if (int'(mem[base]) > max_depth) begin
                max_depth = mem[base];
            end
            base += HDR_WORDS + 2 * int'(mem[base]);
        end
        wd_cycles = (n_tiles + 1) * (max_depth + 2 * FLUSH_DELAY + N_OUT + 10);

        repeat (4) @(posedge clk);                          // 4 cycles of reset
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);             // Quiet before any tile
        check_value("sta_idle", sta_idle, 1);

        base = 1;
        for (int t = 0; t < n_tiles; t++) begin
            issue_tile(base);
            base += HDR_WORDS + 2 * int'(mem[base]);
        end

        repeat (FLUSH_DELAY + N_OUT + 8) @(negedge clk);    // Last drain is fixed length
        if (exp_val_q.size() != 0) begin
            $display("%0d expected results never came out", exp_val_q.size());
            err_count++;
        end
        check_value("out_valid", out_valid, 0);
        check_value("sta_idle", sta_idle, 1);               // Idle again after final result

        $display("Ran %0d tiles: %0d checks, %0d errors", n_tiles, n_checks, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ========================================================================
    // Output monitor, sampled mid-cycle
    // ========================================================================

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_val_q.size() == 0) begin
                $display("Extra result at row %0d col %0d, none expected", out_row, out_col);
                err_count++;
            end else begin
                if (n_recv % N_OUT == 0) begin              // First result of a tile
                    if (done_cyc_q.size() == 0) begin
                        $display("Result came out before its tile's done");
                        err_count++;
                    end else begin
                        first_cyc = done_cyc_q.pop_front() + FLUSH_DELAY + 2;
                        check_value("first out_valid cycle", cyc, first_cyc);
                    end
                end
                check_value("out_val", 32'(out_val), exp_val_q.pop_front());
                check_value("out_row", 32'(out_row), exp_row_q.pop_front());
                check_value("out_col", 32'(out_col), exp_col_q.pop_front());
                check_value("sta_idle", sta_idle, 0);       // Busy while emitting
                n_recv++;
            end
        end
    end

    // Run length bound from tile count and deepest tile
    initial begin
        wait (wd_cycles > 0);
        #(wd_cycles * 10);
        $display("Timed out after %0d cycles with %0d results received", wd_cycles, n_recv);
        $display("Ran %0d tiles: %0d checks, %0d errors", n_tiles, n_checks, err_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* systolic/sta_core.sv */
`timescale 1ns/100ps
`default_nettype none

module sta_core
    import sta_pkg::*;
#(
    parameter int SA_N = SA_N_DEFAULT           // Grid edge, passed to all blocks
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_bias,
    input  sa_acc_t                 bias_value,
    input  logic                    in_valid,
    input  sa_data_t                a_vec [SA_N],
    input  sa_data_t                b_vec [SA_N],
    input  logic                    done,
    input  sa_shift_t               shift,      // Sampled at flush
    input  logic                    relu_bypass,
    output logic                    out_valid,
    output sa_data_t                out_val,
    output logic [$clog2(SA_N)-1:0] out_row,
    output logic [$clog2(SA_N)-1:0] out_col,
    output logic                    sta_idle
);

    logic     flush;
    logic     tile_busy;
    logic     draining;

    // Neighbour links, index 0 is the grid edge
    sa_data_t a_link   [SA_N][SA_N+1];          // Eastward, per row
    logic     a_link_v [SA_N][SA_N+1];
    sa_data_t b_link   [SA_N+1][SA_N];          // Southward, per column
    logic     b_link_v [SA_N+1][SA_N];
    sa_acc_t  acc_grid [SA_N][SA_N];

    sa_feed_if #(.SA_N(SA_N)) u_feed ();

    // ========================================================================
    // Feeder
    // ========================================================================

    sa_skew_feeder #(.SA_N(SA_N)) u_feeder (
        .clk        (clk),
        .reset      (reset),
        .load_bias  (load_bias),
        .bias_value (bias_value),
        .in_valid   (in_valid),
        .a_vec      (a_vec),
        .b_vec      (b_vec),
        .done       (done),
        .feed       (u_feed),
        .flush      (flush),
        .tile_busy  (tile_busy)
    );

    // ========================================================================
    // PE grid
    // ========================================================================

    for (genvar e = 0; e < SA_N; e++) begin : g_edge
        assign a_link[e][0]   = u_feed.a_edge[e];       // West edge
        assign a_link_v[e][0] = u_feed.a_edge_valid[e];
        assign b_link[0][e]   = u_feed.b_edge[e];       // North edge
        assign b_link_v[0][e] = u_feed.b_edge_valid[e];
    end

    for (genvar r = 0; r < SA_N; r++) begin : g_row
        for (genvar c = 0; c < SA_N; c++) begin : g_col
            sa_pe u_pe (
                .clk         (clk),
                .reset       (reset),
                .bias_load   (u_feed.bias_load),
                .bias_value  (u_feed.bias_value),
                .a_in        (a_link[r][c]),
                .b_in        (b_link[r][c]),
                .a_in_valid  (a_link_v[r][c]),
                .b_in_valid  (b_link_v[r][c]),
                .a_out       (a_link[r][c+1]),
                .b_out       (b_link[r+1][c]),
                .a_out_valid (a_link_v[r][c+1]),
                .b_out_valid (b_link_v[r+1][c]),
                .acc         (acc_grid[r][c])
            );
        end
    end

    // ========================================================================
    // Drain
    // ========================================================================

    sa_result_drain #(.SA_N(SA_N)) u_drain (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .acc_grid    (acc_grid),
        .shift       (shift),
        .relu_bypass (relu_bypass),
        .out_valid   (out_valid),
        .out_val     (out_val),
        .out_row     (out_row),
        .out_col     (out_col),
        .draining    (draining)
    );

    assign sta_idle = ~(tile_busy | draining);   // Neither accumulating nor emitting

endmodule

`default_nettype wire

/* logic/sa_result_drain.sv */
`timescale 1ns/100ps
`default_nettype none

module sa_result_drain
    import sta_pkg::*;
#(
    parameter int SA_N = SA_N_DEFAULT           // Grid edge
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,      // Snapshot strobe from the feeder
    input  sa_acc_t                 acc_grid [SA_N][SA_N],
    input  sa_shift_t               shift,
    input  logic                    relu_bypass,
    output logic                    out_valid,
    output sa_data_t                out_val,
    output logic [$clog2(SA_N)-1:0] out_row,
    output logic [$clog2(SA_N)-1:0] out_col,
    output logic                    draining
);

    localparam int IDX_W = $clog2(SA_N);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SA_N - 1);

    sa_acc_t          snap [SA_N][SA_N];        // Frozen tile, grid is free again
    sa_shift_t        shift_q;
    logic             relu_bypass_q;
    logic [IDX_W-1:0] row_q;
    logic [IDX_W-1:0] col_q;
    logic             last_out;                 // Final result of the tile
    sa_acc_t          cur;
    sa_acc_t          shifted;
    sa_acc_t          rect;

    // ========================================================================
    // Snapshot and row-major walk
    // ========================================================================

    always_ff @(posedge clk) begin
        if (flush) begin
            snap          <= acc_grid;
            shift_q       <= shift;             // Per-tile requant settings
            relu_bypass_q <= relu_bypass;
        end
    end

    assign last_out = draining && (row_q == LAST_IDX) && (col_q == LAST_IDX);

    always_ff @(posedge clk) begin
        if (reset) begin
            draining <= 1'b0;
            row_q    <= '0;
            col_q    <= '0;
        end else if (flush) begin
            draining <= 1'b1;                   // First result next cycle
            row_q    <= '0;
            col_q    <= '0;
        end else if (draining) begin
            if (col_q == LAST_IDX) begin
                col_q <= '0;
                row_q <= (row_q == LAST_IDX) ? '0 : row_q + 1'b1;
                if (row_q == LAST_IDX) begin
                    draining <= 1'b0;           // Whole tile sent
                end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // ========================================================================
    // Requantization: shift, ReLU, int8 clamp
    // ========================================================================

    always_comb begin
        cur     = snap[row_q][col_q];
        shifted = cur >>> shift_q;              // Arithmetic, keeps the sign
        if (!relu_bypass_q && shifted < 0) begin
            rect = '0;                          // ReLU
        end else begin
            rect = shifted;
        end
        if (rect > SAT_MAX) begin
            out_val = sa_data_t'(SAT_MAX);
        end else if (rect < SAT_MIN) begin
            out_val = sa_data_t'(SAT_MIN);
        end else begin
            out_val = sa_data_t'(rect);
        end
    end

    assign out_valid = draining;
    assign out_row   = row_q;
    assign out_col   = col_q;

    // Flush spacing is up to the issuer, only the last result may overlap it
    a_no_flush_while_draining : assert property (
        @(posedge clk) disable iff (reset)
        flush |-> (!draining || last_out)
    ) else $error("flush arrived while previous tile still draining");

endmodule

`default_nettype wire

/* systolic/sa_skew_feeder.sv */
`timescale 1ns/100ps
`default_nettype none

module sa_skew_feeder
    import sta_pkg::*;
#(
    parameter int SA_N = SA_N_DEFAULT           // Grid edge
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      load_bias,                // Preload strobe from the top
    input  sa_acc_t   bias_value,
    input  logic      in_valid,                 // One depth step per cycle
    input  sa_data_t  a_vec [SA_N],             // Row operands
    input  sa_data_t  b_vec [SA_N],             // Column operands
    input  logic      done,                     // Last step has been issued
    sa_feed_if.feeder feed,
    output logic      flush,                    // One-cycle snapshot pulse to the drain
    output logic      tile_busy
);

    // Worst-case skew through the grid, corner PE sees its last MAC this late
    localparam int FLUSH_DELAY = 2 * SA_N - 1;
    localparam int CNT_W       = $clog2(FLUSH_DELAY + 1);

    logic [CNT_W-1:0] flush_cnt;                // Zero when idle
    logic             busy_q;

    // ========================================================================
    // Operand skew
    // ========================================================================

    // Lane i serves row i and column i, both need 1 + i register stages
    for (genvar i = 0; i < SA_N; i++) begin : g_lane
        sa_data_t a_dl [i+1];                   // Stage 0 is the input register
        sa_data_t b_dl [i+1];
        logic [i:0] v_dl;                       // Valid travels with the data

        always_ff @(posedge clk) begin
            a_dl[0] <= a_vec[i];
            b_dl[0] <= b_vec[i];
            for (int k = 1; k <= i; k++) begin
                a_dl[k] <= a_dl[k-1];           // Triangular delay
                b_dl[k] <= b_dl[k-1];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                v_dl <= '0;
            end else begin
                v_dl[0] <= in_valid;
                for (int k = 1; k <= i; k++) begin
                    v_dl[k] <= v_dl[k-1];
                end
            end
        end

        // Same valid for row and column of a lane, they share the depth
        assign feed.a_edge[i]       = a_dl[i];
        assign feed.a_edge_valid[i] = v_dl[i];
        assign feed.b_edge[i]       = b_dl[i];
        assign feed.b_edge_valid[i] = v_dl[i];
    end

    // ========================================================================
    // Bias preload and flush timing
    // ========================================================================

    always_ff @(posedge clk) begin
        feed.bias_value <= bias_value;          // Payload, sampled with the strobe
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            feed.bias_load <= 1'b0;
            flush_cnt      <= '0;
            flush          <= 1'b0;
            busy_q         <= 1'b0;
        end else begin
            feed.bias_load <= load_bias;        // Lands one cycle after the top strobe
            flush          <= (flush_cnt == CNT_W'(1));  // Pulse once the count expires
            if (done) begin
                flush_cnt <= CNT_W'(FLUSH_DELAY);
            end else if (flush_cnt != '0) begin
                flush_cnt <= flush_cnt - 1'b1;
            end
            if (load_bias) begin
                busy_q <= 1'b1;                 // New tile starts accumulating
            end else if (flush) begin
                busy_q <= 1'b0;                 // Tile handed to the drain
            end
        end
    end

    // Busy already in the strobe cycle so idle drops at once
    assign tile_busy = load_bias | busy_q;

    // A second done would restart the count and lose the pending flush
    a_no_done_during_flush : assert property (
        @(posedge clk) disable iff (reset)
        done |-> (flush_cnt == '0)
    ) else $error("done asserted while flush delay is still counting");

endmodule

`default_nettype wire

/* systolic/sa_pe.sv */
`timescale 1ns/100ps
`default_nettype none

module sa_pe
    import sta_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     bias_load,                 // Overrides any MAC in the same cycle
    input  sa_acc_t  bias_value,
    input  sa_data_t a_in,                      // From the west neighbour
    input  sa_data_t b_in,                      // From the north neighbour
    input  logic     a_in_valid,
    input  logic     b_in_valid,
    output sa_data_t a_out,                     // To the east neighbour
    output sa_data_t b_out,                     // To the south neighbour
    output logic     a_out_valid,
    output logic     b_out_valid,
    output sa_acc_t  acc                        // Output-stationary result
);

    logic signed [15:0] prod;                   // Full int8 x int8 product

    assign prod = a_in * b_in;

    // Operand forwarding plus the accumulator
    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
        if (bias_load) begin
            acc <= bias_value;                  // Start of a new tile
        end else if (a_in_valid && b_in_valid) begin
            acc <= acc + prod;                  // Sign-extended into 32 bits
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            a_out_valid <= 1'b0;
            b_out_valid <= 1'b0;
        end else begin
            a_out_valid <= a_in_valid;
            b_out_valid <= b_in_valid;
        end
    end

    // Skew in the feeder must line both operands up at every element
    a_operands_aligned : assert property (
        @(posedge clk) disable iff (reset)
        a_in_valid == b_in_valid
    ) else $error("PE operand valids out of step");

endmodule

`default_nettype wire

/* common/sa_feed_if.sv */
`timescale 1ns/100ps
`default_nettype none

// ============================================================================
// Edge feed from the skew feeder into the PE grid
// ============================================================================

interface sa_feed_if
    import sta_pkg::*;
#(
    parameter int SA_N = SA_N_DEFAULT           // Grid edge
) ();

    sa_data_t         a_edge [SA_N];            // West edge, one per row
    logic [SA_N-1:0]  a_edge_valid;             // Skewed valid per row
    sa_data_t         b_edge [SA_N];            // North edge, one per column
    logic [SA_N-1:0]  b_edge_valid;             // Skewed valid per column
    logic             bias_load;                // Preload strobe to every PE
    sa_acc_t          bias_value;               // Common bias for the whole tile

    // Feeder side drives everything
    modport feeder (
        output a_edge,
        output a_edge_valid,
        output b_edge,
        output b_edge_valid,
        output bias_load,
        output bias_value
    );

    // Grid side only listens
    modport grid (
        input a_edge,
        input a_edge_valid,
        input b_edge,
        input b_edge_valid,
        input bias_load,
        input bias_value
    );

endinterface

`default_nettype wire

/* common/sta_pkg.sv */
`default_nettype none

// ============================================================================
// Shared types and constants of the systolic tile
// ============================================================================

package sta_pkg;

    // Operand and requantized activation
    typedef logic signed [7:0]  sa_data_t;

    // Accumulator, wide enough for bias plus long dot products
    typedef logic signed [31:0] sa_acc_t;

    // Requantization right-shift amount, 0..31
    typedef logic [4:0]         sa_shift_t;

    // Default grid edge, top level overrides through SA_N
    localparam int SA_N_DEFAULT = 4;

    // int8 saturation bounds applied after shift and ReLU
    localparam int SAT_MAX = 127;
    localparam int SAT_MIN = -128;

endpackage

`default_nettype wire
